// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_axi_ram -f tb.f -o sim_axi_ram

./obj_dir/sim_axi_ram | tee sim.log

if grep -q "Testbench passed" sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

// File: sim/axi_ram_assertions.sv
`timescale 1ns/1ps

module axi_ram_assertions (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         rvalid,
    input logic                         rready,
    input logic [axi_ram_pkg::data_w-1:0] rdata,
    input logic [axi_ram_pkg::id_w-1:0] rid,
    input logic                         rlast,
    input logic                         bvalid,
    input logic                         bready,
    input logic [axi_ram_pkg::id_w-1:0] bid
);

    int r_fail_count = 0;
    int b_fail_count = 0;
    int reset_fail_count = 0;

    // R beat is held until the master takes it.
    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid) && $stable(rlast))
    else begin
        $error("R channel changed while rvalid waited for rready");
        r_fail_count = r_fail_count + 1;
    end

    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bid))
    else begin
        $error("B channel changed while bvalid waited for bready");
        b_fail_count = b_fail_count + 1;
    end

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !rvalid && !bvalid)
    else begin
        $error("rvalid or bvalid high during reset");
        reset_fail_count = reset_fail_count + 1;
    end

endmodule

bind axi_ram_top axi_ram_assertions u_assert (
    .clk    (clk),
    .rst_n  (rst_n),
    .rvalid (rvalid),
    .rready (rready),
    .rdata  (rdata),
    .rid    (rid),
    .rlast  (rlast),
    .bvalid (bvalid),
    .bready (bready),
    .bid    (bid)
);

// File: sim/tb_axi_ram.sv
`timescale 1ns/1ps

module tb_axi_ram;

    localparam int num_rows   = 16;
    localparam int wait_limit = 200;
    localparam logic op_wr = 1'b1;
    localparam logic op_rd = 1'b0;
    localparam axi_ram_pkg::burst_kind_e fix = axi_ram_pkg::burst_fixed;
    localparam axi_ram_pkg::burst_kind_e inc = axi_ram_pkg::burst_incr;

    typedef struct packed {
        logic                           is_write;
        logic [axi_ram_pkg::id_w-1:0]   id;
        logic [axi_ram_pkg::addr_w-1:0] addr;
        logic [axi_ram_pkg::len_w-1:0]  len;
        logic [axi_ram_pkg::size_w-1:0] size;
        axi_ram_pkg::burst_kind_e       burst;
        logic [axi_ram_pkg::strb_w-1:0] strb;
        logic [31:0]                    dseed;
        logic                           bp;
    } row_t;

    logic                           clk;
    logic                           rst_n;
    logic                           awvalid;
    logic                           awready;
    logic [axi_ram_pkg::id_w-1:0]   awid;
    logic [axi_ram_pkg::addr_w-1:0] awaddr;
    logic [axi_ram_pkg::len_w-1:0]  awlen;
    logic [axi_ram_pkg::size_w-1:0] awsize;
    logic [1:0]                     awburst;
    logic                           wvalid;
    logic                           wready;
    logic [axi_ram_pkg::data_w-1:0] wdata;
    logic [axi_ram_pkg::strb_w-1:0] wstrb;
    logic                           wlast;
    logic                           bvalid;
    logic                           bready;
    logic [axi_ram_pkg::id_w-1:0]   bid;
    logic                           arvalid;
    logic                           arready;
    logic [axi_ram_pkg::id_w-1:0]   arid;
    logic [axi_ram_pkg::addr_w-1:0] araddr;
    logic [axi_ram_pkg::len_w-1:0]  arlen;
    logic [axi_ram_pkg::size_w-1:0] arsize;
    logic [1:0]                     arburst;
    logic                           rvalid;
    logic                           rready;
    logic [axi_ram_pkg::data_w-1:0] rdata;
    logic [axi_ram_pkg::id_w-1:0]   rid;
    logic                           rlast;

    row_t       rows [num_rows];
    logic [7:0] ref_mem [axi_ram_pkg::mem_bytes];
    integer     rand_seed;
    int         cur_row;
    int         mismatch_count;
    int         protocol_count;
    int         timeout_count;

    axi_ram_top DUT (.*);

    always #2 clk = ~clk;

    task automatic fill_table();
        // Op, id, addr, len, size, burst, strobes, data seed, back-pressure.
        rows[0]  = '{op_wr, 4'h1, 12'h100, 8'd3,  3'd2, inc, 4'hf, 32'h00000000, 1'b0};
        rows[1]  = '{op_rd, 4'h2, 12'h100, 8'd3,  3'd2, inc, 4'hf, 32'h00000000, 1'b0};
        rows[2]  = '{op_wr, 4'h3, 12'h104, 8'd1,  3'd2, inc, 4'h5, 32'h5a5a5a5a, 1'b0};
        rows[3]  = '{op_rd, 4'h4, 12'h100, 8'd3,  3'd2, inc, 4'hf, 32'h00000000, 1'b0};
        rows[4]  = '{op_wr, 4'h5, 12'h200, 8'd7,  3'd0, inc, 4'h1, 32'h0f0f0f0f, 1'b0};
        rows[5]  = '{op_rd, 4'h6, 12'h200, 8'd7,  3'd0, inc, 4'hf, 32'h00000000, 1'b0};
        rows[6]  = '{op_wr, 4'h7, 12'h300, 8'd3,  3'd1, inc, 4'h3, 32'h12345678, 1'b0};
        rows[7]  = '{op_rd, 4'h8, 12'h300, 8'd3,  3'd1, inc, 4'hf, 32'h00000000, 1'b0};
        rows[8]  = '{op_rd, 4'h9, 12'h201, 8'd2,  3'd1, inc, 4'hf, 32'h00000000, 1'b0};
        rows[9]  = '{op_wr, 4'ha, 12'h400, 8'd3,  3'd2, fix, 4'hf, 32'hc3c3c3c3, 1'b0};
        rows[10] = '{op_rd, 4'hb, 12'h400, 8'd3,  3'd2, fix, 4'hf, 32'h00000000, 1'b0};
        rows[11] = '{op_rd, 4'hc, 12'h400, 8'd0,  3'd2, inc, 4'hf, 32'h00000000, 1'b0};
        rows[12] = '{op_wr, 4'hd, 12'h500, 8'd15, 3'd2, inc, 4'hf, 32'h9e3779b9, 1'b1};
        rows[13] = '{op_rd, 4'he, 12'h500, 8'd15, 3'd2, inc, 4'hf, 32'h00000000, 1'b1};
        rows[14] = '{op_rd, 4'hf, 12'h502, 8'd9,  3'd1, fix, 4'hf, 32'h00000000, 1'b1};
        rows[15] = '{op_rd, 4'h0, 12'h100, 8'd15, 3'd0, inc, 4'hf, 32'h00000000, 1'b1};
    endtask

    // Byte address of lane l in beat b.
    function automatic logic [11:0] byte_addr(input row_t r, input int b, input int l);
        int n;
        n = 1 << r.size;
        if (r.burst == axi_ram_pkg::burst_fixed) begin
            return r.addr + 12'(l);
        end
        return r.addr + 12'(b * n + l);
    endfunction

    function automatic logic [31:0] expect_beat(input row_t r, input int b);
        logic [31:0] beat;
        int n;
        n = 1 << r.size;
        beat = '0;
        for (int l = 0; l < n; l++) begin
            beat[8*l +: 8] = ref_mem[byte_addr(r, b, l)];
        end
        return beat;
    endfunction

    function automatic logic pick_ready(input logic bp);
        if (!bp) begin
            return 1'b1;
        end
        return (($random(rand_seed) & 32'h3) != 32'h0);
    endfunction

    task automatic finish_run();
        int total;
        int assert_fails;
        assert_fails = DUT.u_assert.r_fail_count + DUT.u_assert.b_fail_count
                     + DUT.u_assert.reset_fail_count;
        total = mismatch_count + protocol_count + timeout_count + assert_fails;
        $display("Errors: %0d mismatches, %0d protocol, %0d timeouts, %0d assertions",
                 mismatch_count, protocol_count, timeout_count, assert_fails);
        if (total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        $display("Timeout waiting for %s in row %0d", what, cur_row);
        timeout_count++;
    endtask

    // Called and returns on a falling edge.
    task automatic run_write(input row_t r);
        int n;
        int cycles;
        logic done;
        n = 1 << r.size;
        awvalid = 1'b1;
        awid    = r.id;
        awaddr  = r.addr;
        awlen   = r.len;
        awsize  = r.size;
        awburst = r.burst;
        cycles  = 0;
        #1;
        while (!awready) begin
            @(negedge clk);
            #1;
            cycles++;
            if (cycles > wait_limit) begin
                timed_out("awready");
                return;
            end
        end
        @(negedge clk);
        awvalid = 1'b0;
        for (int b = 0; b <= int'(r.len); b++) begin
            wvalid = 1'b1;
            wdata  = $random(rand_seed) ^ r.dseed;
            wstrb  = r.strb;
            wlast  = (b == int'(r.len));
            for (int l = 0; l < n; l++) begin
                if (r.strb[l]) begin
                    ref_mem[byte_addr(r, b, l)] = wdata[8*l +: 8];
                end
            end
            cycles = 0;
            #1;
            while (!wready) begin
                @(negedge clk);
                #1;
                cycles++;
                if (cycles > wait_limit) begin
                    timed_out("wready");
                    return;
                end
            end
            @(negedge clk);
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        done   = 1'b0;
        cycles = 0;
        while (!done) begin
            bready = pick_ready(r.bp);
            #1;
            if (bvalid && bready) begin
                if (bid !== r.id) begin
                    $display("Mismatch bid: row %0d expected %h got %h", cur_row, r.id, bid);
                    mismatch_count++;
                end
                done = 1'b1;
            end else begin
                cycles++;
                if (cycles > wait_limit) begin
                    timed_out("bvalid");
                    return;
                end
            end
            @(negedge clk);
        end
        bready = 1'b0;
        #1;
        if (bvalid) begin
            $display("Second write response seen after row %0d", cur_row);
            protocol_count++;
        end
        @(negedge clk);
    endtask

    task automatic run_read(input row_t r);
        int cycles;
        logic done;
        logic [31:0] exp_data;
        logic exp_last;
        arvalid = 1'b1;
        arid    = r.id;
        araddr  = r.addr;
        arlen   = r.len;
        arsize  = r.size;
        arburst = r.burst;
        cycles  = 0;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
            cycles++;
            if (cycles > wait_limit) begin
                timed_out("arready");
                return;
            end
        end
        @(negedge clk);
        arvalid = 1'b0;
        for (int b = 0; b <= int'(r.len); b++) begin
            exp_data = expect_beat(r, b);
            exp_last = (b == int'(r.len));
            done     = 1'b0;
            cycles   = 0;
            while (!done) begin
                rready = pick_ready(r.bp);
                #1;
                if (rvalid && rready) begin
                    if (rdata !== exp_data) begin
                        $display("Mismatch rdata: row %0d beat %0d expected %h got %h",
                                 cur_row, b, exp_data, rdata);
                        mismatch_count++;
                    end
                    if (rid !== r.id) begin
                        $display("Mismatch rid: row %0d expected %h got %h", cur_row, r.id, rid);
                        mismatch_count++;
                    end
                    if (rlast !== exp_last) begin
                        $display("Mismatch rlast: row %0d beat %0d expected %h got %h",
                                 cur_row, b, exp_last, rlast);
                        mismatch_count++;
                    end
                    done = 1'b1;
                end else begin
                    cycles++;
                    if (cycles > wait_limit) begin
                        timed_out("rvalid");
                        return;
                    end
                end
                @(negedge clk);
            end
        end
        rready = 1'b0;
        #1;
        if (rvalid) begin
            $display("Extra read beat after the last one in row %0d", cur_row);
            protocol_count++;
        end
        @(negedge clk);
    endtask

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        awvalid = 1'b0;
        awid    = '0;
        awaddr  = '0;
        awlen   = '0;
        awsize  = '0;
        awburst = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wlast   = 1'b0;
        bready  = 1'b0;
        arvalid = 1'b0;
        arid    = '0;
        araddr  = '0;
        arlen   = '0;
        arsize  = '0;
        arburst = '0;
        rready  = 1'b0;
        rand_seed      = 32'h4e0a;
        cur_row        = 0;
        mismatch_count = 0;
        protocol_count = 0;
        timeout_count  = 0;
        fill_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        #1;
        // Idle state right after reset.
        if (rvalid !== 1'b0) begin
            $display("Mismatch rvalid after reset: expected 0 got %h", rvalid);
            mismatch_count++;
        end
        if (bvalid !== 1'b0) begin
            $display("Mismatch bvalid after reset: expected 0 got %h", bvalid);
            mismatch_count++;
        end
        if (arready !== 1'b1) begin
            $display("Mismatch arready after reset: expected 1 got %h", arready);
            mismatch_count++;
        end
        if (awready !== 1'b1) begin
            $display("Mismatch awready after reset: expected 1 got %h", awready);
            mismatch_count++;
        end
        @(negedge clk);
        for (int i = 0; i < num_rows; i++) begin
            cur_row = i;
            if (rows[i].is_write) begin
                run_write(rows[i]);
            end else begin
                run_read(rows[i]);
            end
            // A stuck handshake leaves the DUT mid-burst.
            if (timeout_count != 0) begin
                break;
            end
        end
        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule

// File: tb.f
verilog/axi_ram_pkg.sv
verilog/byte_ram.sv
verilog/axi_write_engine.sv
verilog/axi_read_engine.sv
verilog/axi_ram_top.sv
sim/axi_ram_assertions.sv
sim/tb_axi_ram.sv

// File: verilog/axi_ram_pkg.sv
package axi_ram_pkg;

    localparam int addr_w    = 12;
    localparam int id_w      = 4;
    localparam int data_w    = 32;
    localparam int strb_w    = 4;
    localparam int len_w     = 8;
    localparam int size_w    = 3;
    localparam int mem_bytes = 4096;

    // Bits needed to index a byte lane.
    localparam int lane_w = $clog2(strb_w);

    typedef enum logic [1:0] {
        burst_fixed = 2'd0,
        burst_incr  = 2'd1
    } burst_kind_e;

    typedef enum logic [1:0] {
        st_addr,
        st_data,
        st_resp
    } engine_state_e;

    // Last lane used by a beat of 2^size bytes.
    function automatic logic [lane_w-1:0] last_lane_of(input logic [size_w-1:0] size);
        logic [lane_w-1:0] last;
        last = '0;
        for (int i = 0; i < strb_w; i++) begin
            if (i < (1 << size)) begin
                last = i[lane_w-1:0];
            end
        end
        return last;
    endfunction

endpackage

// File: verilog/axi_ram_top.sv
`timescale 1ns/1ps

module axi_ram_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [axi_ram_pkg::id_w-1:0]   awid,
    input  logic [axi_ram_pkg::addr_w-1:0] awaddr,
    input  logic [axi_ram_pkg::len_w-1:0]  awlen,
    input  logic [axi_ram_pkg::size_w-1:0] awsize,
    input  logic [1:0]                     awburst,
    input  logic                           wvalid,
    output logic                           wready,
    input  logic [axi_ram_pkg::data_w-1:0] wdata,
    input  logic [axi_ram_pkg::strb_w-1:0] wstrb,
    input  logic                           wlast,
    output logic                           bvalid,
    input  logic                           bready,
    output logic [axi_ram_pkg::id_w-1:0]   bid,
    input  logic                           arvalid,
    output logic                           arready,
    input  logic [axi_ram_pkg::id_w-1:0]   arid,
    input  logic [axi_ram_pkg::addr_w-1:0] araddr,
    input  logic [axi_ram_pkg::len_w-1:0]  arlen,
    input  logic [axi_ram_pkg::size_w-1:0] arsize,
    input  logic [1:0]                     arburst,
    output logic                           rvalid,
    input  logic                           rready,
    output logic [axi_ram_pkg::data_w-1:0] rdata,
    output logic [axi_ram_pkg::id_w-1:0]   rid,
    output logic                           rlast
);

    logic                           wr_en;
    logic [axi_ram_pkg::addr_w-1:0] wr_addr;
    logic [7:0]                     wr_data;
    logic [axi_ram_pkg::addr_w-1:0] rd_addr;
    logic [7:0]                     rd_data;

    axi_write_engine u_write (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awid    (awid),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awsize  (awsize),
        .awburst (awburst),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wlast   (wlast),
        .bvalid  (bvalid),
        .bid     (bid),
        .bready  (bready),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    byte_ram u_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    axi_read_engine u_read (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (arvalid),
        .arready (arready),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rid     (rid),
        .rlast   (rlast),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: verilog/axi_read_engine.sv
`timescale 1ns/1ps

module axi_read_engine (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           arvalid,
    output logic                           arready,
    input  logic [axi_ram_pkg::id_w-1:0]   arid,
    input  logic [axi_ram_pkg::addr_w-1:0] araddr,
    input  logic [axi_ram_pkg::len_w-1:0]  arlen,
    input  logic [axi_ram_pkg::size_w-1:0] arsize,
    input  logic [1:0]                     arburst,
    output logic                           rvalid,
    input  logic                           rready,
    output logic [axi_ram_pkg::data_w-1:0] rdata,
    output logic [axi_ram_pkg::id_w-1:0]   rid,
    output logic                           rlast,
    output logic [axi_ram_pkg::addr_w-1:0] rd_addr,
    input  logic [7:0]                     rd_data
);

    axi_ram_pkg::engine_state_e state;
    axi_ram_pkg::burst_kind_e   burst;

    logic [axi_ram_pkg::id_w-1:0]   id;
    logic [axi_ram_pkg::addr_w-1:0] base_addr;
    logic [axi_ram_pkg::addr_w-1:0] cur_addr;
    logic [axi_ram_pkg::len_w-1:0]  beats_left;
    logic [axi_ram_pkg::lane_w-1:0] last_lane;
    logic [axi_ram_pkg::lane_w-1:0] lane;
    logic [axi_ram_pkg::lane_w-1:0] cap_lane;
    logic [axi_ram_pkg::data_w-1:0] beat_q;
    logic                           issue_done;
    logic                           cap_en;
    logic                           ar_fire;
    logic                           r_fire;
    logic                           issue;
    logic                           beat_full;

    assign ar_fire   = arvalid && arready;
    assign r_fire    = rvalid && rready;
    assign issue     = (state == axi_ram_pkg::st_data) && !issue_done;
    assign beat_full = cap_en && (cap_lane == last_lane);

    assign arready = (state == axi_ram_pkg::st_addr);
    assign rvalid  = (state == axi_ram_pkg::st_resp);
    assign rlast   = rvalid && (beats_left == '0);
    assign rdata   = beat_q;
    assign rid     = id;
    assign rd_addr = cur_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= axi_ram_pkg::st_addr;
            lane       <= '0;
            beats_left <= '0;
            issue_done <= 1'b0;
            cap_en     <= 1'b0;
        end else begin
            case (state)
                axi_ram_pkg::st_addr: begin
                    if (ar_fire) begin
                        state      <= axi_ram_pkg::st_data;
                        lane       <= '0;
                        beats_left <= arlen;
                        issue_done <= 1'b0;
                        cap_en     <= 1'b0;
                    end
                end
                axi_ram_pkg::st_data: begin
                    // Returned byte lands one cycle after its address.
                    cap_en <= issue;
                    if (issue) begin
                        if (lane == last_lane) begin
                            lane       <= '0;
                            issue_done <= 1'b1;
                        end else begin
                            lane <= lane + 1'b1;
                        end
                    end
                    if (beat_full) begin
                        state <= axi_ram_pkg::st_resp;
                    end
                end
                axi_ram_pkg::st_resp: begin
                    if (rready) begin
                        if (beats_left == '0) begin
                            state <= axi_ram_pkg::st_addr;
                        end else begin
                            state      <= axi_ram_pkg::st_data;
                            beats_left <= beats_left - 1'b1;
                            issue_done <= 1'b0;
                        end
                    end
                end
                default: begin
                    state <= axi_ram_pkg::st_addr;
                end
            endcase
        end
    end

    // Request fields, byte address and lane registers.
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            id        <= arid;
            base_addr <= araddr;
            cur_addr  <= araddr;
            last_lane <= axi_ram_pkg::last_lane_of(arsize);
            burst     <= axi_ram_pkg::burst_kind_e'(arburst);
            beat_q    <= '0;
        end else if (r_fire) begin
            beat_q <= '0;
        end else begin
            if (issue) begin
                cap_lane <= lane;
                if (lane == last_lane && burst == axi_ram_pkg::burst_fixed) begin
                    cur_addr <= base_addr;
                end else begin
                    cur_addr <= cur_addr + 1'b1;
                end
            end
            if (cap_en) begin
                beat_q[{cap_lane, 3'b000} +: 8] <= rd_data;
            end
        end
    end

endmodule

// File: verilog/axi_write_engine.sv
`timescale 1ns/1ps

module axi_write_engine (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [axi_ram_pkg::id_w-1:0]   awid,
    input  logic [axi_ram_pkg::addr_w-1:0] awaddr,
    input  logic [axi_ram_pkg::len_w-1:0]  awlen,
    input  logic [axi_ram_pkg::size_w-1:0] awsize,
    input  logic [1:0]                     awburst,
    input  logic                           wvalid,
    output logic                           wready,
    input  logic [axi_ram_pkg::data_w-1:0] wdata,
    input  logic [axi_ram_pkg::strb_w-1:0] wstrb,
    input  logic                           wlast,
    output logic                           bvalid,
    output logic [axi_ram_pkg::id_w-1:0]   bid,
    input  logic                           bready,
    output logic                           wr_en,
    output logic [axi_ram_pkg::addr_w-1:0] wr_addr,
    output logic [7:0]                     wr_data
);

    axi_ram_pkg::engine_state_e state;
    axi_ram_pkg::burst_kind_e   burst;

    logic [axi_ram_pkg::id_w-1:0]   id;
    logic [axi_ram_pkg::addr_w-1:0] base_addr;
    logic [axi_ram_pkg::addr_w-1:0] cur_addr;
    logic [axi_ram_pkg::len_w-1:0]  beats_left;
    logic [axi_ram_pkg::lane_w-1:0] last_lane;
    logic [axi_ram_pkg::lane_w-1:0] lane;
    logic                           aw_fire;
    logic                           byte_step;
    logic                           beat_end;

    assign aw_fire   = awvalid && awready;
    assign byte_step = (state == axi_ram_pkg::st_data) && wvalid;
    assign beat_end  = byte_step && (lane == last_lane);

    assign awready = (state == axi_ram_pkg::st_addr);
    assign bvalid  = (state == axi_ram_pkg::st_resp);
    assign bid     = id;

    // Beat is taken only on its last lane.
    assign wready  = beat_end;

    assign wr_en   = byte_step && wstrb[lane];
    assign wr_addr = cur_addr;
    assign wr_data = wdata[{lane, 3'b000} +: 8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= axi_ram_pkg::st_addr;
            lane       <= '0;
            beats_left <= '0;
        end else begin
            case (state)
                axi_ram_pkg::st_addr: begin
                    if (aw_fire) begin
                        state      <= axi_ram_pkg::st_data;
                        lane       <= '0;
                        beats_left <= awlen;
                    end
                end
                axi_ram_pkg::st_data: begin
                    if (beat_end) begin
                        lane       <= '0;
                        beats_left <= beats_left - 1'b1;
                        if (beats_left == '0 || wlast) begin
                            state <= axi_ram_pkg::st_resp;
                        end
                    end else if (byte_step) begin
                        lane <= lane + 1'b1;
                    end
                end
                axi_ram_pkg::st_resp: begin
                    if (bready) begin
                        state <= axi_ram_pkg::st_addr;
                    end
                end
                default: begin
                    state <= axi_ram_pkg::st_addr;
                end
            endcase
        end
    end

    // Request fields and the running byte address.
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            id        <= awid;
            base_addr <= awaddr;
            cur_addr  <= awaddr;
            last_lane <= axi_ram_pkg::last_lane_of(awsize);
            burst     <= axi_ram_pkg::burst_kind_e'(awburst);
        end else if (byte_step) begin
            // FIXED beats all start at the request address.
            if (beat_end && burst == axi_ram_pkg::burst_fixed) begin
                cur_addr <= base_addr;
            end else begin
                cur_addr <= cur_addr + 1'b1;
            end
        end
    end

endmodule

// File: verilog/byte_ram.sv
`timescale 1ns/1ps

module byte_ram (
    input  logic                           clk,
    input  logic                           wr_en,
    input  logic [axi_ram_pkg::addr_w-1:0] wr_addr,
    input  logic [7:0]                     wr_data,
    input  logic [axi_ram_pkg::addr_w-1:0] rd_addr,
    output logic [7:0]                     rd_data
);

    logic [7:0] mem [axi_ram_pkg::mem_bytes];

    // Byte write port.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read port.
    // A write to the same byte in this cycle is not yet visible.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule
